/* logic/magic_pkg.sv */
package magic_pkg;

    // **************************************************
    // Machine configuration encodings
    // **************************************************

    typedef enum logic [2:0] {
        MACHINE_48   = 3'd0,
        MACHINE_128  = 3'd1,
        MACHINE_PENT = 3'd2,
        MACHINE_S3   = 3'd3
    } machine_t;

    typedef enum logic [2:0] {
        TURBO_NONE = 3'd0,
        TURBO_X2   = 3'd1,
        TURBO_X4   = 3'd2,
        TURBO_X8   = 3'd3
    } turbo_t;

    typedef enum logic [1:0] {
        PANNING_MONO = 2'd0,
        PANNING_ABC  = 2'd1,
        PANNING_ACB  = 2'd2
    } panning_t;

    // **************************************************
    // Service-mode controller
    // **************************************************

    typedef enum logic [2:0] {
        ST_NORMAL    = 3'd0,
        ST_NMI_WAIT  = 3'd1,
        ST_CHECK     = 3'd2,
        ST_CHECK_END = 3'd3,
        ST_MAPPED    = 3'd4,
        ST_UNMAP     = 3'd5
    } magic_state_t;

    // Register index comes from the high byte of the port xxFF address.
    typedef enum logic [7:0] {
        CFG_STATUS     = 8'h00,
        CFG_SYSTEM     = 8'h01,
        CFG_MACHINE    = 8'h02,
        CFG_TURBO      = 8'h03,
        CFG_PANNING    = 8'h04,
        CFG_ROM_CUSTOM = 8'h05,
        CFG_ROM_ALT48  = 8'h06,
        CFG_JOY        = 8'h07,
        CFG_AY         = 8'h08,
        CFG_DIVMMC     = 8'h09,
        CFG_ULAPLUS    = 8'h0A,
        CFG_SD_COVOX   = 8'h0B
    } cfg_reg_t;

endpackage

/* logic/frame_int_timer.sv */
`timescale 1ns/1ps

module frame_int_timer #(
    parameter int FRAME_CYCLES = 560000,
    parameter int INT_WIDTH    = 896
) (
    input  logic clk28,
    input  logic rst_n,
    output logic n_int,
    output logic n_int_next
);

    localparam int CNT_W = $clog2(FRAME_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FRAME_CYCLES - 1);
    localparam logic [CNT_W-1:0] INT_TAIL = CNT_W'(INT_WIDTH - 1);

    logic [CNT_W-1:0] cnt;
    logic             armed;

    // The window opens on the last count of a frame and runs on into the
    // start of the next one. The first frame after reset has no tail.
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            armed <= 1'b0;
        end else begin
            if (cnt == CNT_LAST) begin
                cnt   <= '0;
                armed <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign n_int_next = !((cnt == CNT_LAST) || (armed && (cnt < INT_TAIL)));

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            n_int <= 1'b1;
        end else begin
            n_int <= n_int_next;
        end
    end

endmodule

/* logic/magic_fsm.sv */
`timescale 1ns/1ps

module magic_fsm (
    input  logic        clk28,
    input  logic        rst_n,

    input  logic [15:0] a,
    input  logic [7:0]  d,
    input  logic        mreq,
    input  logic        rd,
    input  logic        m1,

    input  logic        n_int,
    input  logic        n_int_next,

    input  logic        magic_button,
    input  logic        pause_button,

    output logic        n_nmi,
    output logic        magic_mode,
    output logic        magic_map
);

    magic_pkg::magic_state_t state;

    logic remap_pending;
    logic opcode_match;

    logic nmi_req;
    logic fetch;
    logic fetch_rd;
    logic mem_rd;

    // Buttons are only taken on the falling edge of the frame interrupt.
    assign nmi_req  = (magic_button || pause_button) && n_int && !n_int_next;

    assign fetch    = mreq && m1;
    assign fetch_rd = mreq && m1 && rd;
    assign mem_rd   = mreq && rd;

    // **************************************************
    // Mapping state machine
    // **************************************************

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            state         <= magic_pkg::ST_CHECK;
            magic_mode    <= 1'b1;
            n_nmi         <= 1'b1;
            remap_pending <= 1'b0;
            opcode_match  <= 1'b0;
        end else begin
            if (nmi_req) begin
                if (!magic_mode) begin
                    n_nmi <= 1'b0;
                end
                magic_mode <= 1'b1;
            end

            case (state)
                magic_pkg::ST_NORMAL: begin
                    if (nmi_req) begin
                        state <= magic_pkg::ST_NMI_WAIT;
                    end
                end

                magic_pkg::ST_NMI_WAIT: begin
                    if (fetch && (a == 16'h0066 || remap_pending)) begin
                        n_nmi         <= 1'b1;
                        remap_pending <= 1'b0;
                        // A remap after a 0xF008 exit skips the opcode check.
                        if (a == 16'h0066) begin
                            state <= magic_pkg::ST_CHECK;
                        end else begin
                            state <= magic_pkg::ST_MAPPED;
                        end
                    end
                end

                magic_pkg::ST_CHECK: begin
                    if (fetch_rd) begin
                        opcode_match <= (d == 8'hEB);
                        state        <= magic_pkg::ST_CHECK_END;
                    end
                end

                magic_pkg::ST_CHECK_END: begin
                    // Keep sampling until the fetch strobe goes away.
                    if (fetch_rd) begin
                        opcode_match <= (d == 8'hEB);
                    end else if (opcode_match) begin
                        state <= magic_pkg::ST_MAPPED;
                    end else begin
                        magic_mode <= 1'b0;
                        state      <= magic_pkg::ST_NORMAL;
                    end
                end

                magic_pkg::ST_MAPPED: begin
                    if (mem_rd && a == 16'hF000) begin
                        magic_mode <= 1'b0;
                        state      <= magic_pkg::ST_UNMAP;
                    end else if (mem_rd && a == 16'hF008) begin
                        remap_pending <= 1'b1;
                        state         <= magic_pkg::ST_UNMAP;
                    end
                end

                magic_pkg::ST_UNMAP: begin
                    if (!mreq) begin
                        if (magic_mode || nmi_req) begin
                            state <= magic_pkg::ST_NMI_WAIT;
                        end else begin
                            state <= magic_pkg::ST_NORMAL;
                        end
                    end
                end

                default: begin
                    state <= magic_pkg::ST_NORMAL;
                end
            endcase
        end
    end

    assign magic_map = (state == magic_pkg::ST_CHECK)     ||
                       (state == magic_pkg::ST_CHECK_END) ||
                       (state == magic_pkg::ST_MAPPED)    ||
                       (state == magic_pkg::ST_UNMAP);

endmodule

/* logic/magic_config.sv */
`timescale 1ns/1ps

module magic_config (
    input  logic                  clk28,
    input  logic                  rst_n,

    input  logic [15:0]           a,
    input  logic [7:0]            d,
    input  logic                  ioreq,
    input  logic                  rd,
    input  logic                  wr,

    input  logic                  magic_map,
    input  logic                  magic_button,
    input  logic                  pause_button,
    input  logic                  div_automap,

    output logic [7:0]            d_out,
    output logic                  d_out_active,

    output logic                  magic_reboot,
    output logic                  magic_beeper,
    output logic                  rom_wren,
    output magic_pkg::machine_t   machine,
    output magic_pkg::turbo_t     turbo,
    output magic_pkg::panning_t   panning,
    output logic                  rom_custom_en,
    output logic [1:0]            rom_custom,
    output logic                  rom_alt48_en,
    output logic                  rom_alt48,
    output logic                  joy_sinclair,
    output logic                  divmmc_en,
    output logic                  zc_en,
    output logic                  ulaplus_en,
    output logic                  ay_en,
    output logic                  covox_en,
    output logic                  sd_en
);

    logic                config_cs;
    magic_pkg::cfg_reg_t reg_idx;

    // Port xxFF is only visible while the service ROM is mapped.
    assign config_cs = magic_map && ioreq && (a[7:0] == 8'hFF);
    assign reg_idx   = magic_pkg::cfg_reg_t'(a[15:8]);

    // **************************************************
    // Configuration registers
    // **************************************************

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            magic_reboot  <= 1'b0;
            magic_beeper  <= 1'b0;
            rom_wren      <= 1'b0;
            machine       <= magic_pkg::MACHINE_PENT;
            turbo         <= magic_pkg::TURBO_NONE;
            panning       <= magic_pkg::PANNING_ABC;
            rom_custom_en <= 1'b0;
            rom_custom    <= 2'b00;
            rom_alt48_en  <= 1'b0;
            rom_alt48     <= 1'b0;
            joy_sinclair  <= 1'b0;
            divmmc_en     <= 1'b0;
            zc_en         <= 1'b1;
            ulaplus_en    <= 1'b1;
            ay_en         <= 1'b1;
            covox_en      <= 1'b1;
            sd_en         <= 1'b1;
        end else if (config_cs && wr) begin
            case (reg_idx)
                magic_pkg::CFG_SYSTEM:     {rom_wren, magic_reboot, magic_beeper} <= d[2:0];
                magic_pkg::CFG_MACHINE:    machine <= magic_pkg::machine_t'(d[2:0]);
                magic_pkg::CFG_TURBO:      turbo <= magic_pkg::turbo_t'(d[2:0]);
                magic_pkg::CFG_PANNING:    panning <= magic_pkg::panning_t'(d[1:0]);
                magic_pkg::CFG_ROM_CUSTOM: {rom_custom_en, rom_custom} <= {d[7], d[1:0]};
                // Either alternative 48K ROM enables the swap.
                magic_pkg::CFG_ROM_ALT48:  {rom_alt48_en, rom_alt48} <= {d[0] | d[1], d[1]};
                magic_pkg::CFG_JOY:        joy_sinclair <= d[0];
                magic_pkg::CFG_AY:         ay_en <= d[0];
                magic_pkg::CFG_DIVMMC:     {zc_en, divmmc_en} <= d[1:0];
                magic_pkg::CFG_ULAPLUS:    ulaplus_en <= d[0];
                magic_pkg::CFG_SD_COVOX:   {sd_en, covox_en} <= d[1:0];
                default: begin
                end
            endcase
        end
    end

    // **************************************************
    // Status read-back on port 0x00FF
    // **************************************************

    assign d_out = {4'b0000, div_automap, 1'b1, pause_button, magic_button};

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            d_out_active <= 1'b0;
        end else begin
            d_out_active <= config_cs && rd && (reg_idx == magic_pkg::CFG_STATUS);
        end
    end

endmodule

/* logic/magic_top.sv */
`timescale 1ns/1ps

module magic_top #(
    parameter int FRAME_CYCLES = 560000,
    parameter int INT_WIDTH    = 896
) (
    input  logic                  clk28,
    input  logic                  rst_n,

    input  logic [15:0]           a,
    input  logic [7:0]            d,
    input  logic                  mreq,
    input  logic                  ioreq,
    input  logic                  rd,
    input  logic                  wr,
    input  logic                  m1,

    input  logic                  magic_button,
    input  logic                  pause_button,
    input  logic                  div_automap,

    output logic                  n_nmi,
    output logic                  magic_mode,
    output logic                  magic_map,
    output logic [7:0]            d_out,
    output logic                  d_out_active,

    output logic                  magic_reboot,
    output logic                  magic_beeper,
    output logic                  rom_wren,
    output magic_pkg::machine_t   machine,
    output magic_pkg::turbo_t     turbo,
    output magic_pkg::panning_t   panning,
    output logic                  rom_custom_en,
    output logic [1:0]            rom_custom,
    output logic                  rom_alt48_en,
    output logic                  rom_alt48,
    output logic                  joy_sinclair,
    output logic                  divmmc_en,
    output logic                  zc_en,
    output logic                  ulaplus_en,
    output logic                  ay_en,
    output logic                  covox_en,
    output logic                  sd_en
);

    logic n_int;
    logic n_int_next;

    frame_int_timer #(
        .FRAME_CYCLES (FRAME_CYCLES),
        .INT_WIDTH    (INT_WIDTH)
    ) frame_int_timer_i (
        .clk28      (clk28),
        .rst_n      (rst_n),
        .n_int      (n_int),
        .n_int_next (n_int_next)
    );

    magic_fsm magic_fsm_i (
        .clk28        (clk28),
        .rst_n        (rst_n),
        .a            (a),
        .d            (d),
        .mreq         (mreq),
        .rd           (rd),
        .m1           (m1),
        .n_int        (n_int),
        .n_int_next   (n_int_next),
        .magic_button (magic_button),
        .pause_button (pause_button),
        .n_nmi        (n_nmi),
        .magic_mode   (magic_mode),
        .magic_map    (magic_map)
    );

    magic_config magic_config_i (
        .clk28         (clk28),
        .rst_n         (rst_n),
        .a             (a),
        .d             (d),
        .ioreq         (ioreq),
        .rd            (rd),
        .wr            (wr),
        .magic_map     (magic_map),
        .magic_button  (magic_button),
        .pause_button  (pause_button),
        .div_automap   (div_automap),
        .d_out         (d_out),
        .d_out_active  (d_out_active),
        .magic_reboot  (magic_reboot),
        .magic_beeper  (magic_beeper),
        .rom_wren      (rom_wren),
        .machine       (machine),
        .turbo         (turbo),
        .panning       (panning),
        .rom_custom_en (rom_custom_en),
        .rom_custom    (rom_custom),
        .rom_alt48_en  (rom_alt48_en),
        .rom_alt48     (rom_alt48),
        .joy_sinclair  (joy_sinclair),
        .divmmc_en     (divmmc_en),
        .zc_en         (zc_en),
        .ulaplus_en    (ulaplus_en),
        .ay_en         (ay_en),
        .covox_en      (covox_en),
        .sd_en         (sd_en)
    );

endmodule

/* bench/magic_asserts.sv */
`timescale 1ns/1ps

module magic_asserts (
    input logic clk28,
    input logic rst_n,
    input logic n_nmi,
    input logic magic_mode,
    input logic n_int,
    input logic n_int_next,
    input logic ioreq,
    input logic rd,
    input logic d_out_active
);

    int fail_count = 0;

    // An NMI can only be pending once service mode is on.
    nmi_needs_mode: assert property (@(posedge clk28) disable iff (!rst_n)
        !n_nmi |-> magic_mode)
        else begin
            $error("n_nmi is low while magic_mode is off");
            fail_count++;
        end

    // The look-ahead output leads the frame interrupt by one cycle.
    int_lookahead: assert property (@(posedge clk28) disable iff (!rst_n)
        n_int == $past(n_int_next))
        else begin
            $error("n_int does not follow n_int_next by one cycle");
            fail_count++;
        end

    status_after_read: assert property (@(posedge clk28) disable iff (!rst_n)
        $rose(d_out_active) |-> $past(ioreq && rd))
        else begin
            $error("d_out_active rose without an I/O read");
            fail_count++;
        end

endmodule

bind magic_top magic_asserts magic_asserts_i (
    .clk28        (clk28),
    .rst_n        (rst_n),
    .n_nmi        (n_nmi),
    .magic_mode   (magic_mode),
    .n_int        (n_int),
    .n_int_next   (n_int_next),
    .ioreq        (ioreq),
    .rd           (rd),
    .d_out_active (d_out_active)
);

/* bench/tb_magic_top.sv */
`timescale 1ns/1ps

module tb_magic_top;

    localparam int TIMEOUT_CYCLES = 500;
    localparam int FRAME_CYCLES   = 200;
    localparam int INT_WIDTH      = 8;

    logic                clk28;
    logic                rst_n;
    logic [15:0]         a;
    logic [7:0]          d;
    logic                mreq;
    logic                ioreq;
    logic                rd;
    logic                wr;
    logic                m1;
    logic                magic_button;
    logic                pause_button;
    logic                div_automap;

    logic                n_nmi;
    logic                magic_mode;
    logic                magic_map;
    logic [7:0]          d_out;
    logic                d_out_active;
    logic                magic_reboot;
    logic                magic_beeper;
    logic                rom_wren;
    magic_pkg::machine_t machine;
    magic_pkg::turbo_t   turbo;
    magic_pkg::panning_t panning;
    logic                rom_custom_en;
    logic [1:0]          rom_custom;
    logic                rom_alt48_en;
    logic                rom_alt48;
    logic                joy_sinclair;
    logic                divmmc_en;
    logic                zc_en;
    logic                ulaplus_en;
    logic                ay_en;
    logic                covox_en;
    logic                sd_en;

    int       errors       = 0;
    int       test_errs    = 0;
    int       tests_run    = 0;
    int       tests_failed = 0;
    bit       timed_out    = 1'b0;
    // Bits 3..0 of trace hold magic_map and bits 7..4 magic_mode, one per clock of a bus cycle.
    logic [7:0] trace;
    int         act_cnt;
    bit         act_early;
    logic [7:0] act_val;
    int         cycles_since_reset;

    magic_top #(
        .FRAME_CYCLES (FRAME_CYCLES),
        .INT_WIDTH    (INT_WIDTH)
    ) magic_top_i (.*);

    initial clk28 = 1'b0;
    always #2 clk28 = ~clk28;

    // Clock edges since reset release, used to predict the frame interrupt.
    always @(posedge clk28) begin
        if (!rst_n) begin
            cycles_since_reset <= 0;
        end else begin
            cycles_since_reset <= cycles_since_reset + 1;
        end
    end

    // The frame interrupt falls every FRAME_CYCLES edges after reset release.
    function automatic bit frame_edge(input int cycles);
        frame_edge = (cycles != 0) && (cycles % FRAME_CYCLES == 0);
    endfunction

    function automatic logic [7:0] read_output(input logic [15:0] sel);
        case (sel)
            16'h0001: read_output = {5'b0, rom_wren, magic_reboot, magic_beeper};
            16'h0002: read_output = {5'b0, machine};
            16'h0003: read_output = {5'b0, turbo};
            16'h0004: read_output = {6'b0, panning};
            16'h0005: read_output = {rom_custom_en, 5'b0, rom_custom};
            16'h0006: read_output = {6'b0, rom_alt48_en, rom_alt48};
            16'h0007: read_output = {7'b0, joy_sinclair};
            16'h0008: read_output = {7'b0, ay_en};
            16'h0009: read_output = {6'b0, zc_en, divmmc_en};
            16'h000A: read_output = {7'b0, ulaplus_en};
            16'h000B: read_output = {6'b0, sd_en, covox_en};
            16'h0100: read_output = {7'b0, magic_map};
            16'h0101: read_output = {7'b0, magic_mode};
            16'h0102: read_output = {7'b0, n_nmi};
            default:  read_output = 8'hxx;
        endcase
    endfunction

    function automatic string output_name(input logic [15:0] sel);
        case (sel)
            16'h0001: output_name = "rom_wren/magic_reboot/magic_beeper";
            16'h0002: output_name = "machine";
            16'h0003: output_name = "turbo";
            16'h0004: output_name = "panning";
            16'h0005: output_name = "rom_custom_en/rom_custom";
            16'h0006: output_name = "rom_alt48_en/rom_alt48";
            16'h0007: output_name = "joy_sinclair";
            16'h0008: output_name = "ay_en";
            16'h0009: output_name = "zc_en/divmmc_en";
            16'h000A: output_name = "ulaplus_en";
            16'h000B: output_name = "sd_en/covox_en";
            16'h0100: output_name = "magic_map";
            16'h0101: output_name = "magic_mode";
            16'h0102: output_name = "n_nmi";
            default:  output_name = "unknown output";
        endcase
    endfunction

    task automatic count_error();
        errors++;
        test_errs++;
    endtask

    task automatic report_value(input string name, input logic [7:0] got,
                                input logic [7:0] exp_val);
        $display("ERROR %s: got 0x%02h, expected 0x%02h", name, got, exp_val);
        count_error();
    endtask

    task automatic reset_dut();
        @(posedge clk28);
        rst_n <= 1'b0;
        repeat (8) @(posedge clk28);
        rst_n <= 1'b1;
    endtask

    // **************************************************
    // Bus cycles with strobes up, hold, strobes down and idle
    // **************************************************

    task automatic bus_cycle(input logic [7:0] kind, input logic [15:0] addr,
                             input logic [7:0] data);
        trace     = 8'h00;
        act_cnt   = 0;
        act_early = 1'b0;
        act_val   = 8'h00;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk28);
            if (i == 0) begin
                a     <= addr;
                d     <= data;
                mreq  <= (kind == "F" || kind == "R");
                ioreq <= (kind == "W" || kind == "I");
                rd    <= (kind != "W");
                wr    <= (kind == "W");
                m1    <= (kind == "F");
            end else if (i == 2) begin
                mreq  <= 1'b0;
                ioreq <= 1'b0;
                rd    <= 1'b0;
                wr    <= 1'b0;
                m1    <= 1'b0;
            end
            @(negedge clk28);
            trace = {magic_mode, trace[7:5], magic_map, trace[3:1]};
            if (d_out_active) begin
                if (i == 0) begin
                    act_early = 1'b1;
                end
                act_cnt++;
                act_val = d_out;
            end
        end
    endtask

    // The NMI may only fall on a frame interrupt edge, and must not miss one.
    task automatic wait_nmi();
        int n;
        n = 0;
        @(negedge clk28);
        while (n_nmi && n < TIMEOUT_CYCLES) begin
            @(negedge clk28);
            if (n_nmi && frame_edge(cycles_since_reset)) begin
                $display("n_nmi stayed high through a falling frame interrupt.");
                count_error();
            end
            if (!n_nmi && !frame_edge(cycles_since_reset)) begin
                $display("n_nmi went low away from a falling frame interrupt.");
                count_error();
            end
            n++;
        end
        if (n_nmi) begin
            $display("Timed out after %0d cycles waiting for n_nmi.", TIMEOUT_CYCLES);
            count_error();
            timed_out = 1'b1;
        end
    endtask

    task automatic run_step(input logic [7:0] cmd, input logic [15:0] addr,
                            input logic [7:0] data, input logic [7:0] exp_val);
        case (cmd)
            "F", "R": begin
                bus_cycle(cmd, addr, data);
                if (trace !== exp_val) begin
                    report_value("magic_mode/magic_map trace", trace, exp_val);
                end
            end
            "W": bus_cycle(cmd, addr, data);
            "I": begin
                bus_cycle(cmd, addr, 8'h00);
                if (data[0]) begin
                    if (act_early || act_cnt != 2) begin
                        $display("d_out_active was not one cycle behind the read strobe.");
                        count_error();
                    end
                    if (act_val !== exp_val) begin
                        report_value("d_out", act_val, exp_val);
                    end
                end else if (act_cnt != 0) begin
                    $display("d_out_active rose on an I/O read with the ROM unmapped.");
                    count_error();
                end
            end
            "B": begin
                @(posedge clk28);
                magic_button <= data[0];
                pause_button <= data[1];
                div_automap  <= data[2];
                if (exp_val[0]) begin
                    wait_nmi();
                end
            end
            "X": reset_dut();
            "C": begin
                @(negedge clk28);
                if (read_output(addr) !== exp_val) begin
                    report_value(output_name(addr), read_output(addr), exp_val);
                end
            end
            "T": begin
                tests_run++;
                if (test_errs == 0) begin
                    $display("Test %0d: ok", addr);
                end else begin
                    tests_failed++;
                    $display("Test %0d: failed with %0d errors", addr, test_errs);
                end
                test_errs = 0;
            end
            default: begin
                $display("Unknown command '%c' in the test data.", cmd);
                count_error();
            end
        endcase
    endtask

    initial begin
        int               fd;
        int               r;
        logic [7:0]       cmd;
        logic [15:0]      addr;
        logic [7:0]       data;
        logic [7:0]       exp_val;
        logic [8*128-1:0] skip;
        bit               done;
        done         = 1'b0;
        rst_n        <= 1'b0;
        a            <= 16'h0000;
        d            <= 8'h00;
        mreq         <= 1'b0;
        ioreq        <= 1'b0;
        rd           <= 1'b0;
        wr           <= 1'b0;
        m1           <= 1'b0;
        magic_button <= 1'b0;
        pause_button <= 1'b0;
        div_automap  <= 1'b0;
        repeat (8) @(posedge clk28);
        rst_n <= 1'b1;

        fd = $fopen("bench/magic_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/magic_testdata.txt.");
            errors++;
            done = 1'b1;
        end
        while (!done) begin
            r = $fscanf(fd, " %c", cmd);
            if (r != 1) begin
                done = 1'b1;
            end else if (cmd == "#") begin
                r = $fgets(skip, fd);
            end else begin
                r = $fscanf(fd, " %h %h %h", addr, data, exp_val);
                if (r != 3) begin
                    $display("A line of the test data is incomplete.");
                    errors++;
                    done = 1'b1;
                end else begin
                    run_step(cmd, addr, data, exp_val);
                    done = timed_out;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (magic_top_i.magic_asserts_i.fail_count != 0) begin
            $display("%0d assertion failures were reported.",
                     magic_top_i.magic_asserts_i.fail_count);
            errors += magic_top_i.magic_asserts_i.fail_count;
        end
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* magic_top.f */
logic/magic_pkg.sv
logic/frame_int_timer.sv
logic/magic_fsm.sv
logic/magic_config.sv
logic/magic_top.sv
bench/magic_asserts.sv
bench/tb_magic_top.sv

/* Makefile */
TOP := tb_magic_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build the testbench with Verilator and run it"
	@echo "  make clean  remove the Verilator build directory"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f magic_top.f --Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

/* bench/magic_testdata.txt */
# Columns (hex): cmd addr data expect. F/R fetch/read (expect = mode/map trace), W/I io write/read,
# B buttons {automap,pause,magic}, X reset, T end test; C compares output at addr with expect.
X 0000 00 00
F 0000 EB FF
C 0100 00 01
C 0101 00 01
X 0000 00 00
F 0000 00 77
C 0100 00 00
C 0101 00 00
T 0001 00 00
B 0000 01 01
C 0102 00 00
C 0101 00 01
C 0100 00 00
B 0000 00 00
F 0066 EB FE
C 0102 00 01
C 0100 00 01
T 0004 00 00
C 0002 00 02
W 01FF 05 00
C 0001 00 05
W 02FF 03 00
C 0002 00 03
W 03FF 02 00
C 0003 00 02
W 04FF 02 00
C 0004 00 02
W 05FF 82 00
C 0005 00 82
W 06FF 02 00
C 0006 00 03
W 07FF 01 00
C 0007 00 01
W 08FF 00 00
C 0008 00 00
W 09FF 01 00
C 0009 00 01
W 0AFF 00 00
C 000A 00 00
W 0BFF 02 00
C 000B 00 02
T 0002 00 00
B 0000 05 00
I 00FF 01 0D
B 0000 02 00
I 00FF 01 06
B 0000 00 00
T 0003 00 00
R F000 00 17
C 0101 00 00
C 0100 00 00
W 02FF 00 00
C 0002 00 03
I 00FF 00 00
B 0000 02 01
B 0000 00 00
F 0066 EB FE
R F008 00 F7
C 0101 00 01
C 0100 00 00
F 1234 00 FE
C 0100 00 01
T 0005 00 00
